//--- sources.f
hdl/videoTxPkg.sv
hdl/videoTxCsr.sv
hdl/videoTimingGen.sv
hdl/backlightPwm.sv
hdl/videoTxTop.sv
tb/videoTxTb.sv

//--- Makefile
# Verilator build and run for the video transmit testbench

TOP := videoTxTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'All tests passed'

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- tb/videoTxTb.sv
// testbench for the video transmit subsystem
// register read-back, derived sync counts, measured panel timing,
// backlight duty counts and the reset pins

`timescale 1ns/1ps

module videoTxTb;

	localparam logic [7:0]  lpBlock      = 8'h05;
	localparam int          lpHdisplay   = 480;
	localparam int          lpHfront     = 8;
	localparam int          lpHback      = 43;
	localparam int          lpHpulse     = 30;
	localparam int          lpVdisplay   = 272;
	localparam int          lpVfront     = 12;
	localparam int          lpVback      = 4;
	localparam int          lpVpulse     = 10;
	localparam logic [23:0] lpIdle       = 24'h000000;	// block 0, never a hit
	localparam int          lpRdTimeout  = 10;
	localparam int          lpPinTimeout = 600;
	localparam int          lpPwmPeriod  = 255;
	localparam int          lpPinDe      = 0;
	localparam int          lpPinH       = 1;
	localparam int          lpPinV       = 2;

	logic               iSysClk;
	logic               rst;
	videoTxPkg::busWr_s busWr;
	videoTxPkg::busRd_s busRd;
	logic               hSync;
	logic               vSync;
	logic               de;
	logic               displayRst;
	logic               blPwm;

	integer      seed;
	int          errCount;
	int          checkCount;
	int          errBase;
	logic [15:0] hModel [4];	// display, back, front, pulse
	logic [15:0] vModel [4];
	string       pinNames [3] = '{"de", "hSync", "vSync"};

	videoTxTop #(
		.pAdrsMap (lpBlock), .pHdisplay (lpHdisplay), .pHfront (lpHfront),
		.pHback (lpHback), .pHpulse (lpHpulse), .pVdisplay (lpVdisplay),
		.pVfront (lpVfront), .pVback (lpVback), .pVpulse (lpVpulse)
	) i_videoTxTop (
		.iSysClk (iSysClk), .rst (rst), .busWr (busWr), .busRd (busRd),
		.hSync (hSync), .vSync (vSync), .de (de),
		.displayRst (displayRst), .blPwm (blPwm)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #4 iSysClk = ~iSysClk;
	end

	// --------------------
	// always-on checks
	aResetQuiet: assert property (@(posedge iSysClk)
		rst |=> !(hSync || vSync || de || blPwm || displayRst || busRd.rEd))
	else
	begin
		errCount++;
		$display("[FAIL] %0t ns: outputs active after a reset cycle", $time);
	end

	// sync windows start past display + front porch
	aDeOutsideSync: assert property (@(posedge iSysClk) !(de && (hSync || vSync)))
	else
	begin
		errCount++;
		$display("[FAIL] %0t ns: de high together with a sync pulse", $time);
	end

	// --------------------
	// helpers
	function automatic logic [23:0] regAdrs(input logic [15:0] ofs);
		return {lpBlock, ofs};
	endfunction

	// start, end or max count of one axis, 12-bit wrap
	function automatic logic [15:0] syncCount(input int disp, front, pulse, back, which);
		int sum;
		sum = disp + front;
		if (which > 0)
			sum = sum + pulse - 1;
		if (which > 1)
			sum = sum + back;
		return 16'(sum & 32'hfff);
	endfunction

	function automatic logic [31:0] modelSync(input int which);
		return {syncCount(int'(vModel[0]), int'(vModel[2]), int'(vModel[3]),
				int'(vModel[1]), which),
			syncCount(int'(hModel[0]), int'(hModel[2]), int'(hModel[3]),
				int'(hModel[1]), which)};
	endfunction

	function automatic logic [15:0] fieldMask(input int idx, dispW, porchW);
		int w;
		w = (idx == 0) ? dispW : porchW;
		return 16'((1 << w) - 1);
	endfunction

	function automatic logic pinLevel(input int pin);
		case (pin)
			lpPinDe: return de;
			lpPinH:  return hSync;
			default: return vSync;
		endcase
	endfunction

	task automatic expectWord(input logic [31:0] got, exp, input string what);
		checkCount++;
		assert (got == exp)
		else
		begin
			errCount++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic writeReg(input logic [23:0] adrs, input logic [31:0] data);
		@(posedge iSysClk);
		busWr <= '{adrs: adrs, wd: data, wCke: 1'b1};
		@(posedge iSysClk);
		busWr <= '{adrs: lpIdle, wd: 32'd0, wCke: 1'b0};
	endtask

	task automatic readReg(input logic [23:0] adrs, output logic [31:0] data);
		int waitCnt;
		data = '0;
		waitCnt = 0;
		@(posedge iSysClk);
		busWr <= '{adrs: adrs, wd: 32'd0, wCke: 1'b0};
		@(posedge iSysClk);
		busWr <= '{adrs: lpIdle, wd: 32'd0, wCke: 1'b0};
		@(negedge iSysClk);
		while (!busRd.rEd && waitCnt < lpRdTimeout)
		begin
			@(negedge iSysClk);
			waitCnt++;
		end
		if (busRd.rEd)
			data = busRd.rd;
		else
		begin
			errCount++;
			$display("read of %h got no valid pulse within %0d cycles", adrs, lpRdTimeout);
		end
	endtask

	task automatic checkRead(input logic [15:0] ofs, input logic [31:0] exp, input string what);
		logic [31:0] got;
		readReg(regAdrs(ofs), got);
		expectWord(got, exp, what);
	endtask

	task automatic checkDerived();
		checkRead(videoTxPkg::cOfsSyncStart, modelSync(0), "sync start");
		checkRead(videoTxPkg::cOfsSyncEnd, modelSync(1), "sync end");
		checkRead(videoTxPkg::cOfsSyncMax, modelSync(2), "sync max");
	endtask

	task automatic writePair(input int idx);
		writeReg(regAdrs(16'(idx * 4)), {vModel[idx], hModel[idx]});
	endtask

	// steps at least one falling edge, then until the pin has the level
	task automatic waitPin(input int pin, input logic level, output int steps);
		steps = 0;
		do
		begin
			@(negedge iSysClk);
			steps++;
		end while (pinLevel(pin) != level && steps < lpPinTimeout);
		if (pinLevel(pin) != level)
		begin
			errCount++;
			$display("%s did not reach %0b within %0d cycles", pinNames[pin], level,
				lpPinTimeout);
		end
	endtask

	// length of the high run that starts at the next rising edge of the pin
	task automatic highRun(input int pin, output int len);
		int steps;
		waitPin(pin, 1'b0, steps);
		waitPin(pin, 1'b1, steps);
		len = 0;
		while (pinLevel(pin) && len < lpPinTimeout)
		begin
			@(negedge iSysClk);
			len++;
		end
	endtask

	// de lines between two vSync rising edges
	task automatic countDeLines(output int lines);
		int   steps;
		logic prevDe;
		logic prevV;
		logic rise;
		waitPin(lpPinV, 1'b0, steps);
		waitPin(lpPinV, 1'b1, steps);
		lines = 0;
		steps = 0;
		prevDe = de;
		prevV = vSync;
		do
		begin
			@(negedge iSysClk);
			steps++;
			if (de && !prevDe)
				lines++;
			rise = vSync && !prevV;
			prevDe = de;
			prevV = vSync;
		end while (!rise && steps < 4 * lpPinTimeout);
		if (!rise)
		begin
			errCount++;
			$display("no second vSync pulse within %0d cycles", 4 * lpPinTimeout);
		end
	endtask

	task automatic checkDuty(input logic [7:0] duty);
		int high;
		writeReg(regAdrs(videoTxPkg::cOfsDuty), 32'(duty));
		repeat (lpPwmPeriod + 2) @(negedge iSysClk);	// a latch has passed
		high = 0;
		repeat (lpPwmPeriod)
		begin
			@(negedge iSysClk);
			if (blPwm)
				high++;
		end
		expectWord(32'(high), 32'((int'(duty) < lpPwmPeriod) ? int'(duty) : lpPwmPeriod),
			"pwm high cycles");
	endtask

	task automatic finishTest(input string name);
		if (errCount == errBase)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errCount - errBase);
		errBase = errCount;
	endtask

	// --------------------
	// stimulus
	initial
	begin
		logic [31:0] word;
		int          k1;
		int          k2;
		int          len;
		int          lineLen;
		rst = 1'b1;
		busWr = '0;
		seed = 32'he70f;
		errCount = 0;
		checkCount = 0;
		errBase = 0;
		hModel = '{16'(lpHdisplay), 16'(lpHback), 16'(lpHfront), 16'(lpHpulse)};
		vModel = '{16'(lpVdisplay), 16'(lpVback), 16'(lpVfront), 16'(lpVpulse)};
		repeat (5) @(posedge iSysClk);
		rst <= 1'b0;

		// defaults after reset
		checkRead(videoTxPkg::cOfsDisplay, {16'(lpVdisplay), 16'(lpHdisplay)}, "display");
		checkDerived();
		checkRead(videoTxPkg::cOfsCtrl, 32'h1, "ctrl");
		expectWord(32'({hSync, vSync, de, blPwm}), 32'd0, "pins after reset");
		finishTest("reset defaults");

		for (int i = 0; i < 4; i++)
		begin
			word = $random(seed);
			hModel[i] = word[15:0] & fieldMask(i, videoTxPkg::cHDispW, videoTxPkg::cHPorchW);
			vModel[i] = word[31:16] & fieldMask(i, videoTxPkg::cVDispW, videoTxPkg::cVPorchW);
			writeReg(regAdrs(16'(i * 4)), word);
			checkRead(16'(i * 4), {vModel[i], hModel[i]}, "timing field");
		end
		checkDerived();
		writeReg(regAdrs(16'h0040), $random(seed));
		checkRead(16'h0040, 32'd0, "unmapped offset");
		finishTest("field read-back");

		// the display pair was written above, so a foreign hit would change it
		writeReg({8'h06, videoTxPkg::cOfsDisplay}, ~{vModel[0], hModel[0]});
		repeat (2)
		begin
			@(negedge iSysClk);
			expectWord(32'(busRd.rEd), 32'd0, "valid pulse for another block");
		end
		checkRead(videoTxPkg::cOfsDisplay, {vModel[0], hModel[0]},
			"display after foreign write");
		finishTest("block select");

		hModel = '{16'd16, 16'd3, 16'd2, 16'd4};
		vModel = '{16'd6, 16'd1, 16'd1, 16'd2};
		for (int i = 0; i < 4; i++)
			writePair(i);
		checkDerived();
		word = modelSync(2);
		lineLen = int'(word[15:0]) + 1;
		writeReg(regAdrs(videoTxPkg::cOfsCtrl), 32'h0);	// release the video logic
		highRun(lpPinDe, len);
		expectWord(32'(len), 32'(hModel[0]), "de run");
		highRun(lpPinH, len);
		expectWord(32'(len), 32'(hModel[3]), "hSync run");
		waitPin(lpPinH, 1'b1, k1);
		waitPin(lpPinH, 1'b0, k1);
		waitPin(lpPinH, 1'b1, k2);
		expectWord(32'(k1 + k2), 32'(lineLen), "hSync period");
		highRun(lpPinV, len);
		expectWord(32'(len), 32'(int'(vModel[3]) * lineLen), "vSync run");
		countDeLines(len);
		expectWord(32'(len), 32'(vModel[0]), "de lines per frame");
		finishTest("panel timing");

		checkDuty(8'd0);
		checkDuty(8'd64);
		checkDuty(8'd255);
		finishTest("backlight pwm");

		writeReg(regAdrs(videoTxPkg::cOfsCtrl), 32'h2);
		@(negedge iSysClk);
		expectWord(32'(displayRst), 32'd1, "displayRst pin");
		waitPin(lpPinDe, 1'b1, k1);
		writeReg(regAdrs(videoTxPkg::cOfsCtrl), 32'h3);
		k1 = 0;
		do
		begin
			@(negedge iSysClk);
			k1++;
		end while ((hSync || vSync || de) && k1 < 2);
		expectWord(32'({hSync, vSync, de}), 32'd0, "timing pins under videoRst");
		checkRead(videoTxPkg::cOfsCtrl, 32'h3, "ctrl");
		finishTest("reset pins");

		$display("%0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- hdl/videoTxTop.sv
// video transmit top
// register block steering the timing generator and the backlight pwm

`timescale 1ns/1ps

module videoTxTop #(
	parameter logic [videoTxPkg::cBlockW-1:0] pAdrsMap = 8'h05,
	parameter int pHdisplay = 480,
	parameter int pHfront   = 8,
	parameter int pHback    = 43,
	parameter int pHpulse   = 30,
	parameter int pVdisplay = 272,
	parameter int pVfront   = 12,
	parameter int pVback    = 4,
	parameter int pVpulse   = 10
)(
	input  logic               iSysClk,
	input  logic               rst,
	input  videoTxPkg::busWr_s busWr,
	output videoTxPkg::busRd_s busRd,
	output logic               hSync,
	output logic               vSync,
	output logic               de,
	output logic               displayRst,
	output logic               blPwm
);

	videoTxPkg::timingCfg_s cfg;
	logic                   videoRst;
	logic [7:0]             duty;

	// --------------------
	// registers
	videoTxCsr #(
		.pAdrsMap  (pAdrsMap),
		.pHdisplay (pHdisplay),
		.pHfront   (pHfront),
		.pHback    (pHback),
		.pHpulse   (pHpulse),
		.pVdisplay (pVdisplay),
		.pVfront   (pVfront),
		.pVback    (pVback),
		.pVpulse   (pVpulse)
	) i_videoTxCsr (
		.iSysClk    (iSysClk),
		.rst        (rst),
		.busWr      (busWr),
		.busRd      (busRd),
		.cfg        (cfg),
		.videoRst   (videoRst),
		.displayRst (displayRst),	// straight to the panel pin
		.duty       (duty)
	);

	// --------------------
	// panel timing
	videoTimingGen i_videoTimingGen (
		.iSysClk  (iSysClk),
		.rst      (rst),
		.videoRst (videoRst),
		.cfg      (cfg),
		.hSync    (hSync),
		.vSync    (vSync),
		.de       (de)
	);

	// backlight dimming
	backlightPwm i_backlightPwm (
		.iSysClk (iSysClk),
		.rst     (rst),
		.duty    (duty),
		.blPwm   (blPwm)
	);

endmodule

//--- hdl/backlightPwm.sv
// backlight pwm
// 255-cycle period, duty taken once per period so a change never
// cuts a pulse short

`timescale 1ns/1ps

module backlightPwm (
	input  logic       iSysClk,
	input  logic       rst,
	input  logic [7:0] duty,
	output logic       blPwm
);

	localparam logic [7:0] lpCntLast = 8'd254;

	logic [7:0] cnt;
	logic [7:0] dutyQ;	// latched duty

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			cnt   <= 8'd0;
			dutyQ <= 8'd0;
			blPwm <= 1'b0;
		end
		else
		begin
			if (cnt == lpCntLast)
			begin
				cnt   <= 8'd0;
				dutyQ <= duty;	// in effect from count 0
			end
			else
			begin
				cnt <= cnt + 8'd1;
			end
			blPwm <= cnt < dutyQ;	// 255 never falls, count stops at 254
		end
	end

	// --------------------
	aZeroDutyLow: assert property (@(posedge iSysClk) disable iff (rst)
		(dutyQ == 8'd0) |=> !blPwm);

endmodule

//--- hdl/videoTimingGen.sv
// video timing generator
// horizontal and vertical counters against the derived sync counts,
// registered hSync, vSync and data-enable

`timescale 1ns/1ps

module videoTimingGen (
	input  logic                   iSysClk,
	input  logic                   rst,
	input  logic                   videoRst,
	input  videoTxPkg::timingCfg_s cfg,
	output logic                   hSync,
	output logic                   vSync,
	output logic                   de
);

	typedef logic [videoTxPkg::cHDispW:0] hCnt_t;
	typedef logic [videoTxPkg::cVDispW:0] vCnt_t;

	hCnt_t hCnt;
	vCnt_t vCnt;
	logic  lineEnd;
	logic  frameEnd;
	logic  hActive;
	logic  vActive;
	logic  hPulseOn;
	logic  vPulseOn;
	logic  holdOff;

	assign holdOff = rst || videoRst;	// both park the counters at zero

	// >= so a shrunk max cannot leave the count stranded above it
	assign lineEnd  = hCnt >= cfg.hSyncMax;
	assign frameEnd = vCnt >= cfg.vSyncMax;

	// --------------------
	// counters
	always_ff @(posedge iSysClk)
	begin
		if (holdOff)
		begin
			hCnt <= '0;
		end
		else if (lineEnd)
		begin
			hCnt <= '0;
		end
		else
		begin
			hCnt <= hCnt + hCnt_t'(1);
		end
	end

	// vertical steps once per line
	always_ff @(posedge iSysClk)
	begin
		if (holdOff)
		begin
			vCnt <= '0;
		end
		else if (lineEnd)
		begin
			if (frameEnd)
				vCnt <= '0;
			else
				vCnt <= vCnt + vCnt_t'(1);
		end
	end

	// --------------------
	// compare
	assign hActive  = hCnt < hCnt_t'(cfg.hDisplay);
	assign vActive  = vCnt < vCnt_t'(cfg.vDisplay);
	assign hPulseOn = (hCnt >= cfg.hSyncStart) && (hCnt <= cfg.hSyncEnd);	// inclusive
	assign vPulseOn = (vCnt >= cfg.vSyncStart) && (vCnt <= cfg.vSyncEnd);

	// outputs one cycle behind the counts
	always_ff @(posedge iSysClk)
	begin
		if (holdOff)
		begin
			hSync <= 1'b0;
			vSync <= 1'b0;
			de    <= 1'b0;
		end
		else
		begin
			hSync <= hPulseOn;	// active high
			vSync <= vPulseOn;
			de    <= hActive && vActive;
		end
	end

	// --------------------
	// timing is only rewritten under videoRst, so the count stays in range
	aHCntRange: assert property (@(posedge iSysClk) disable iff (holdOff)
		hCnt <= cfg.hSyncMax);

endmodule

//--- hdl/videoTxCsr.sv
// video transmit control/status registers
// bus-slave panel timing fields, control bits and backlight duty,
// with registered sync start/end/max sums and a 1-cycle read-back

`timescale 1ns/1ps

module videoTxCsr #(
	parameter logic [videoTxPkg::cBlockW-1:0] pAdrsMap = 8'h05,
	parameter int pHdisplay = 480,
	parameter int pHfront   = 8,
	parameter int pHback    = 43,
	parameter int pHpulse   = 30,
	parameter int pVdisplay = 272,
	parameter int pVfront   = 12,
	parameter int pVback    = 4,
	parameter int pVpulse   = 10
)(
	input  logic                    iSysClk,
	input  logic                    rst,
	input  videoTxPkg::busWr_s      busWr,
	output videoTxPkg::busRd_s      busRd,
	output videoTxPkg::timingCfg_s  cfg,
	output logic                    videoRst,
	output logic                    displayRst,
	output logic [7:0]              duty
);

	typedef logic [videoTxPkg::cHDispW-1:0]  hDisp_t;
	typedef logic [videoTxPkg::cVDispW-1:0]  vDisp_t;
	typedef logic [videoTxPkg::cHPorchW-1:0] hPorch_t;
	typedef logic [videoTxPkg::cVPorchW-1:0] vPorch_t;
	typedef logic [videoTxPkg::cHDispW:0]    hSum_t;
	typedef logic [videoTxPkg::cVDispW:0]    vSum_t;

	// reset-time sums, same rule as the running derivation
	localparam hSum_t lpHSyncStart = hSum_t'(pHdisplay + pHfront);
	localparam hSum_t lpHSyncEnd   = hSum_t'(pHdisplay + pHfront + pHpulse - 1);
	localparam hSum_t lpHSyncMax   = hSum_t'(pHdisplay + pHfront + pHpulse + pHback - 1);
	localparam vSum_t lpVSyncStart = vSum_t'(pVdisplay + pVfront);
	localparam vSum_t lpVSyncEnd   = vSum_t'(pVdisplay + pVfront + pVpulse - 1);
	localparam vSum_t lpVSyncMax   = vSum_t'(pVdisplay + pVfront + pVpulse + pVback - 1);

	hDisp_t  hDisplay;
	vDisp_t  vDisplay;
	hPorch_t hFront, hBack, hPulse;
	vPorch_t vFront, vBack, vPulse;
	hSum_t   hSyncStart, hSyncEnd, hSyncMax;
	vSum_t   vSyncStart, vSyncEnd, vSyncMax;

	logic                                blockHit;
	logic                                wrEn;
	logic [videoTxPkg::cCsrAdrsW-1:0]    ofs;
	videoTxPkg::csrWord_u                wrWord;
	videoTxPkg::csrWord_u                rdWord;
	logic [31:0]                         rdQ;
	logic                                rEdQ;

	// --------------------
	// address decode
	assign blockHit = busWr.adrs[videoTxPkg::cBusAdrsW-1 -: videoTxPkg::cBlockW] == pAdrsMap;
	assign ofs      = busWr.adrs[videoTxPkg::cCsrAdrsW-1:0];
	assign wrEn     = busWr.wCke && blockHit;
	assign wrWord   = busWr.wd;

	// --------------------
	// writable registers
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			hDisplay   <= hDisp_t'(pHdisplay);
			hFront     <= hPorch_t'(pHfront);
			hBack      <= hPorch_t'(pHback);
			hPulse     <= hPorch_t'(pHpulse);
			vDisplay   <= vDisp_t'(pVdisplay);
			vFront     <= vPorch_t'(pVfront);
			vBack      <= vPorch_t'(pVback);
			vPulse     <= vPorch_t'(pVpulse);
			videoRst   <= 1'b1;	// video logic held until software releases it
			displayRst <= 1'b0;
			duty       <= 8'd0;
		end
		else if (wrEn)
		begin
			case (ofs)
				videoTxPkg::cOfsDisplay:
				begin
					hDisplay <= hDisp_t'(wrWord.pair.hField);
					vDisplay <= vDisp_t'(wrWord.pair.vField);
				end
				videoTxPkg::cOfsBack:
				begin
					hBack <= hPorch_t'(wrWord.pair.hField);
					vBack <= vPorch_t'(wrWord.pair.vField);
				end
				videoTxPkg::cOfsFront:
				begin
					hFront <= hPorch_t'(wrWord.pair.hField);
					vFront <= vPorch_t'(wrWord.pair.vField);
				end
				videoTxPkg::cOfsPulse:
				begin
					hPulse <= hPorch_t'(wrWord.pair.hField);
					vPulse <= vPorch_t'(wrWord.pair.vField);
				end
				videoTxPkg::cOfsCtrl:
				begin
					videoRst   <= wrWord.ctrl.videoRst;
					displayRst <= wrWord.ctrl.displayRst;
				end
				videoTxPkg::cOfsDuty: duty <= busWr.wd[7:0];
				default: ;	// read-only or unmapped, ignored
			endcase
		end
	end

	// derived counts, one cycle behind the fields
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			hSyncStart <= lpHSyncStart;
			hSyncEnd   <= lpHSyncEnd;
			hSyncMax   <= lpHSyncMax;
			vSyncStart <= lpVSyncStart;
			vSyncEnd   <= lpVSyncEnd;
			vSyncMax   <= lpVSyncMax;
		end
		else
		begin
			hSyncStart <= hSum_t'(hDisplay) + hSum_t'(hFront);
			hSyncEnd   <= hSum_t'(hDisplay) + hSum_t'(hFront) + hSum_t'(hPulse) - hSum_t'(1);
			hSyncMax   <= hSum_t'(hDisplay) + hSum_t'(hFront) + hSum_t'(hPulse)
				+ hSum_t'(hBack) - hSum_t'(1);
			vSyncStart <= vSum_t'(vDisplay) + vSum_t'(vFront);
			vSyncEnd   <= vSum_t'(vDisplay) + vSum_t'(vFront) + vSum_t'(vPulse) - vSum_t'(1);
			vSyncMax   <= vSum_t'(vDisplay) + vSum_t'(vFront) + vSum_t'(vPulse)
				+ vSum_t'(vBack) - vSum_t'(1);
		end
	end

	assign cfg.hDisplay   = hDisplay;
	assign cfg.vDisplay   = vDisplay;
	assign cfg.hSyncStart = hSyncStart;
	assign cfg.hSyncEnd   = hSyncEnd;
	assign cfg.hSyncMax   = hSyncMax;
	assign cfg.vSyncStart = vSyncStart;
	assign cfg.vSyncEnd   = vSyncEnd;
	assign cfg.vSyncMax   = vSyncMax;

	// --------------------
	// read-back, zero filled
	always_comb
	begin
		rdWord = '0;	// unmapped offsets read zero
		case (ofs)
			videoTxPkg::cOfsDisplay:
			begin
				rdWord.pair.vField = 16'(vDisplay);
				rdWord.pair.hField = 16'(hDisplay);
			end
			videoTxPkg::cOfsBack:
			begin
				rdWord.pair.vField = 16'(vBack);
				rdWord.pair.hField = 16'(hBack);
			end
			videoTxPkg::cOfsFront:
			begin
				rdWord.pair.vField = 16'(vFront);
				rdWord.pair.hField = 16'(hFront);
			end
			videoTxPkg::cOfsPulse:
			begin
				rdWord.pair.vField = 16'(vPulse);
				rdWord.pair.hField = 16'(hPulse);
			end
			videoTxPkg::cOfsCtrl:
			begin
				rdWord.ctrl.displayRst = displayRst;
				rdWord.ctrl.videoRst   = videoRst;
			end
			videoTxPkg::cOfsDuty: rdWord = {24'd0, duty};
			videoTxPkg::cOfsSyncStart:
			begin
				rdWord.pair.vField = 16'(vSyncStart);
				rdWord.pair.hField = 16'(hSyncStart);
			end
			videoTxPkg::cOfsSyncEnd:
			begin
				rdWord.pair.vField = 16'(vSyncEnd);
				rdWord.pair.hField = 16'(hSyncEnd);
			end
			videoTxPkg::cOfsSyncMax:
			begin
				rdWord.pair.vField = 16'(vSyncMax);
				rdWord.pair.hField = 16'(hSyncMax);
			end
			default: ;
		endcase
	end

	always_ff @(posedge iSysClk)
	begin
		rdQ <= rdWord;	// payload only, qualified by rEd
		if (rst)
			rEdQ <= 1'b0;
		else
			rEdQ <= blockHit;	// any hit, write or not
	end

	assign busRd.rd  = rdQ;
	assign busRd.rEd = rEdQ;

	// --------------------
	// checks
	aRdFollowsHit: assert property (@(posedge iSysClk) disable iff (rst)
		rEdQ |-> $past(blockHit));

	// a nonzero pulse gives an ordered sync window once the sums settle
	aHSyncOrder: assert property (@(posedge iSysClk) disable iff (rst)
		(hPulse != '0) |=> (hSyncEnd >= hSyncStart));

endmodule

//--- hdl/videoTxPkg.sv
// video transmit package
// field widths, register offsets, bus and timing structs and the
// csr word union shared by the register block and the timing logic

package videoTxPkg;

	// --------------------
	// field widths
	localparam int cHDispW   = 11;
	localparam int cVDispW   = 11;
	localparam int cHPorchW  = 7;	// h porch and pulse
	localparam int cVPorchW  = 5;	// v porch and pulse
	localparam int cCsrAdrsW = 16;	// offset inside the block
	localparam int cBlockW   = 8;	// block select above the offset
	localparam int cBusAdrsW = 24;

	// --------------------
	// register offsets
	localparam logic [cCsrAdrsW-1:0] cOfsDisplay   = 16'h0000;
	localparam logic [cCsrAdrsW-1:0] cOfsBack      = 16'h0004;
	localparam logic [cCsrAdrsW-1:0] cOfsFront     = 16'h0008;
	localparam logic [cCsrAdrsW-1:0] cOfsPulse     = 16'h000c;
	localparam logic [cCsrAdrsW-1:0] cOfsCtrl      = 16'h0010;
	localparam logic [cCsrAdrsW-1:0] cOfsDuty      = 16'h0014;
	localparam logic [cCsrAdrsW-1:0] cOfsSyncStart = 16'h0080;	// read only from here
	localparam logic [cCsrAdrsW-1:0] cOfsSyncEnd   = 16'h0084;
	localparam logic [cCsrAdrsW-1:0] cOfsSyncMax   = 16'h0088;

	// --------------------
	// bus
	typedef struct packed {
		logic [cBusAdrsW-1:0] adrs;
		logic [31:0]          wd;
		logic                 wCke;	// one-cycle write strobe
	} busWr_s;

	typedef struct packed {
		logic [31:0] rd;
		logic        rEd;	// valid, one cycle after a block hit
	} busRd_s;

	// derived panel timing handed to the generator
	typedef struct packed {
		logic [cHDispW-1:0] hDisplay;
		logic [cVDispW-1:0] vDisplay;
		logic [cHDispW:0]   hSyncStart;
		logic [cHDispW:0]   hSyncEnd;
		logic [cHDispW:0]   hSyncMax;
		logic [cVDispW:0]   vSyncStart;
		logic [cVDispW:0]   vSyncEnd;
		logic [cVDispW:0]   vSyncMax;
	} timingCfg_s;

	// --------------------
	// one bus word, seen as a v/h pair or as the control bits
	typedef struct packed {
		logic [15:0] vField;
		logic [15:0] hField;
	} csrPair_s;

	typedef struct packed {
		logic [29:0] rsvd;
		logic        displayRst;
		logic        videoRst;
	} csrCtrl_s;

	typedef union packed {
		csrPair_s pair;	// 0x00..0x0c, 0x80..0x88
		csrCtrl_s ctrl;	// 0x10
	} csrWord_u;

endpackage
